// File: logic/tg_pkg.sv
// Shared definitions for the traffic-generator cluster
// Widths, programming register map, LFSR feedback and flit word layout
package tg_pkg;

  localparam int unsigned FlitWidth    = 32;
  localparam int unsigned CfgAddrWidth = 8;
  localparam int unsigned RegIdxWidth  = 3;
  localparam int unsigned TileIdxWidth = CfgAddrWidth - RegIdxWidth;

  // Register indices within one tile
  localparam logic [RegIdxWidth-1:0] REG_CTRL  = 3'd0;
  localparam logic [RegIdxWidth-1:0] REG_DST   = 3'd1;
  localparam logic [RegIdxWidth-1:0] REG_LEN   = 3'd2;
  localparam logic [RegIdxWidth-1:0] REG_SEED  = 3'd3;
  localparam logic [RegIdxWidth-1:0] REG_COUNT = 3'd4;
  localparam logic [RegIdxWidth-1:0] REG_SENT  = 3'd5;

  // Galois feedback for the payload LFSR
  localparam logic [FlitWidth-1:0] LfsrTaps = 32'h8020_0003;

  // Header flit, src in the top byte
  typedef struct packed {
    logic [7:0] src;
    logic [7:0] dst;
    logic [7:0] seq;
    logic [7:0] len;
  } tg_hdr_t;

  // One flit word, seen as header or as raw payload
  typedef union packed {
    tg_hdr_t              hdr;
    logic [FlitWidth-1:0] data;
  } flit_word_u;

  // One LFSR step: shift right, fold the taps in on a shifted-out one
  function automatic logic [FlitWidth-1:0] lfsr_step(input logic [FlitWidth-1:0] state);
    logic [FlitWidth-1:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LfsrTaps;
    end
    return next;
  endfunction

endpackage

// File: logic/cfg_dispatch.sv
`timescale 1ns/1ps
// Programming-port dispatcher
// Latches one access, decodes the tile field and runs the four-phase
// exchange toward that tile. Out-of-range tiles are answered here
module cfg_dispatch #(
  parameter int unsigned NumTiles = 4
) (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       cfg_req_i,
  input  logic                                       cfg_we_i,
  input  logic [tg_pkg::CfgAddrWidth-1:0]            cfg_addr_i,
  input  logic [tg_pkg::FlitWidth-1:0]               cfg_wdata_i,
  output logic                                       cfg_ack_o,
  output logic [tg_pkg::FlitWidth-1:0]               cfg_rdata_o,
  output logic [NumTiles-1:0]                        tile_req_o,
  output logic                                       tile_we_o,
  output logic [tg_pkg::RegIdxWidth-1:0]             tile_reg_o,
  output logic [tg_pkg::FlitWidth-1:0]               tile_wdata_o,
  input  logic [NumTiles-1:0]                        tile_ack_i,
  input  logic [NumTiles-1:0][tg_pkg::FlitWidth-1:0] tile_rdata_i
);
  import tg_pkg::*;

  localparam logic [1:0] StIdle = 2'd0;
  localparam logic [1:0] StFwd  = 2'd1;
  localparam logic [1:0] StAck  = 2'd2;
  localparam logic [1:0] StRel  = 2'd3;

  localparam logic [TileIdxWidth:0] TileLimit = NumTiles[TileIdxWidth:0];

  logic [1:0]              state_q;
  logic                    we_q;
  logic [CfgAddrWidth-1:0] addr_q;
  logic [FlitWidth-1:0]    wdata_q;
  logic [FlitWidth-1:0]    rdata_q;
  logic [TileIdxWidth-1:0] sel;
  logic                    in_range;
  logic                    req_phase;
  logic                    sel_ack;
  logic [FlitWidth-1:0]    sel_rdata;

  assign sel       = addr_q[CfgAddrWidth-1:RegIdxWidth];
  assign in_range  = {1'b0, cfg_addr_i[CfgAddrWidth-1:RegIdxWidth]} < TileLimit;
  assign req_phase = (state_q == StFwd) || (state_q == StAck);

  // Out-of-range field matches no tile, so no request and no ack
  always_comb begin
    sel_ack   = 1'b0;
    sel_rdata = '0;
    for (int t = 0; t < NumTiles; t++) begin
      tile_req_o[t] = req_phase && (sel == TileIdxWidth'(t));
      if (sel == TileIdxWidth'(t)) begin
        sel_ack   = tile_ack_i[t];
        sel_rdata = tile_rdata_i[t];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle:  if (cfg_req_i) state_q <= in_range ? StFwd : StAck;
        StFwd:   if (sel_ack) state_q <= StAck;
        StAck:   if (!cfg_req_i) state_q <= StRel;
        StRel:   if (!sel_ack) state_q <= StIdle;
        default: state_q <= StIdle;
      endcase
    end
  end

  // Access capture; local answers read as zero
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && cfg_req_i) begin
      we_q    <= cfg_we_i;
      addr_q  <= cfg_addr_i;
      wdata_q <= cfg_wdata_i;
      rdata_q <= '0;
    end else if (state_q == StFwd && sel_ack) begin
      rdata_q <= sel_rdata;
    end
  end

  assign cfg_ack_o    = (state_q == StAck) || (state_q == StRel);
  assign cfg_rdata_o  = rdata_q;
  assign tile_we_o    = we_q;
  assign tile_reg_o   = addr_q[RegIdxWidth-1:0];
  assign tile_wdata_o = wdata_q;

  a_one_tile_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(tile_req_o));

  a_ack_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cfg_ack_o) |-> $past(cfg_req_i));

endmodule

// File: logic/tg_tile.sv
`timescale 1ns/1ps
// Synthetic-traffic generator tile
// Register block on a four-phase programming port, Galois LFSR and
// a header/payload sequencer with a four-phase flit output
module tg_tile #(
  parameter int unsigned TileId = 0
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           cfg_req_i,
  input  logic                           cfg_we_i,
  input  logic [tg_pkg::RegIdxWidth-1:0] cfg_reg_i,
  input  logic [tg_pkg::FlitWidth-1:0]   cfg_wdata_i,
  output logic                           cfg_ack_o,
  output logic [tg_pkg::FlitWidth-1:0]   cfg_rdata_o,
  output logic                           flit_req_o,
  output logic [tg_pkg::FlitWidth-1:0]   flit_data_o,
  input  logic                           flit_ack_i
);
  import tg_pkg::*;

  localparam logic [1:0] GenIdle    = 2'd0;
  localparam logic [1:0] GenLoad    = 2'd1;
  localparam logic [1:0] GenOffer   = 2'd2;
  localparam logic [1:0] GenRelease = 2'd3;

  logic [7:0]           dst_q;
  logic [7:0]           len_q;
  logic [FlitWidth-1:0] seed_q;
  logic [FlitWidth-1:0] count_q;
  logic [FlitWidth-1:0] sent_q;
  logic [7:0]           seq_q;
  logic [7:0]           pay_cnt_q;
  logic [1:0]           gen_q;
  logic                 is_hdr_q;
  logic                 ack_q;
  logic [FlitWidth-1:0] rdata_q;
  logic [FlitWidth-1:0] read_mux;
  logic [FlitWidth-1:0] lfsr_q;
  logic [FlitWidth-1:0] lfsr_next;
  logic                 flit_req_q;
  logic [FlitWidth-1:0] flit_data_q;
  logic                 busy;
  logic                 wr_en;
  logic                 start;
  logic                 last_flit;
  flit_word_u           hdr_w;

  assign busy      = gen_q != GenIdle;
  assign wr_en     = cfg_req_i && !ack_q && cfg_we_i;
  assign start     = wr_en && (cfg_reg_i == REG_CTRL) && cfg_wdata_i[0] && !busy;
  assign lfsr_next = lfsr_step(lfsr_q);
  // Zero length closes the packet right after its header
  assign last_flit = is_hdr_q ? (len_q == '0) : (pay_cnt_q == 8'd1);

  always_comb begin
    hdr_w.hdr.src = 8'(TileId);
    hdr_w.hdr.dst = dst_q;
    hdr_w.hdr.seq = seq_q;
    hdr_w.hdr.len = len_q;
  end

  always_comb begin
    case (cfg_reg_i)
      REG_CTRL:  read_mux = FlitWidth'(busy);
      REG_DST:   read_mux = FlitWidth'(dst_q);
      REG_LEN:   read_mux = FlitWidth'(len_q);
      REG_SEED:  read_mux = seed_q;
      REG_COUNT: read_mux = count_q;
      REG_SENT:  read_mux = sent_q;
      default:   read_mux = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Programming port and registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      dst_q   <= '0;
      len_q   <= '0;
      seed_q  <= '0;
      count_q <= '0;
    end else begin
      if (cfg_req_i && !ack_q) begin
        ack_q <= 1'b1;
      end else if (!cfg_req_i && ack_q) begin
        ack_q <= 1'b0;
      end
      // Run parameters frozen while busy
      if (wr_en && !busy) begin
        case (cfg_reg_i)
          REG_DST:   dst_q   <= cfg_wdata_i[7:0];
          REG_LEN:   len_q   <= cfg_wdata_i[7:0];
          REG_SEED:  seed_q  <= cfg_wdata_i;
          REG_COUNT: count_q <= cfg_wdata_i;
          default:   ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_req_i && !ack_q) begin
      rdata_q <= read_mux;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Packet sequencer
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gen_q      <= GenIdle;
      is_hdr_q   <= 1'b1;
      pay_cnt_q  <= '0;
      seq_q      <= '0;
      sent_q     <= '0;
      flit_req_q <= 1'b0;
    end else begin
      case (gen_q)
        GenIdle: begin
          if (start) begin
            seq_q    <= '0;
            sent_q   <= '0;
            is_hdr_q <= 1'b1;
            if (count_q != '0) gen_q <= GenLoad;
          end
        end
        GenLoad: begin
          flit_req_q <= 1'b1;
          gen_q      <= GenOffer;
        end
        GenOffer: begin
          if (flit_ack_i) begin
            flit_req_q <= 1'b0;
            gen_q      <= GenRelease;
          end
        end
        default: begin
          // Advance only once the ack has dropped
          if (!flit_ack_i) begin
            gen_q <= GenLoad;
            if (is_hdr_q) begin
              is_hdr_q  <= 1'b0;
              pay_cnt_q <= len_q;
            end else begin
              pay_cnt_q <= pay_cnt_q - 8'd1;
            end
            if (last_flit) begin
              is_hdr_q <= 1'b1;
              seq_q    <= seq_q + 8'd1;
              sent_q   <= sent_q + 1'b1;
              if (sent_q + 1'b1 == count_q) gen_q <= GenIdle;
            end
          end
        end
      endcase
    end
  end

  // LFSR state runs across packets, reloaded only on start
  always_ff @(posedge clk_i) begin
    if (start) begin
      lfsr_q <= seed_q;
    end else if (gen_q == GenLoad && !is_hdr_q) begin
      lfsr_q <= lfsr_next;
    end
    if (gen_q == GenLoad) begin
      flit_data_q <= is_hdr_q ? hdr_w.data : lfsr_next;
    end
  end

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;
  assign flit_req_o  = flit_req_q;
  assign flit_data_o = flit_data_q;

  a_flit_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    flit_req_o |=> !flit_req_o || $stable(flit_data_o));

  a_flit_held: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(flit_req_o) |-> $past(flit_ack_i));

endmodule

// File: logic/flit_collector.sv
`timescale 1ns/1ps
// Flit collector
// Round-robin merge of tile flit streams onto one four-phase port,
// holding each grant for a whole packet
module flit_collector #(
  parameter int unsigned NumTiles = 4
) (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [NumTiles-1:0]                        flit_req_i,
  input  logic [NumTiles-1:0][tg_pkg::FlitWidth-1:0] flit_data_i,
  output logic [NumTiles-1:0]                        flit_ack_o,
  output logic                                       out_req_o,
  output logic [tg_pkg::FlitWidth-1:0]               out_data_o,
  input  logic                                       out_ack_i
);
  import tg_pkg::*;

  localparam int unsigned IdxWidth = (NumTiles > 1) ? $clog2(NumTiles) : 1;

  logic                locked_q;
  logic                ack_seen_q;
  logic                hdr_next_q;
  logic [IdxWidth-1:0] grant_q;
  logic [IdxWidth-1:0] last_q;
  logic [IdxWidth-1:0] pick;
  logic                pick_valid;
  logic [7:0]          rem_q;
  flit_word_u          cur_w;

  assign cur_w.data = flit_data_i[grant_q];
  assign out_req_o  = locked_q && flit_req_i[grant_q];
  assign out_data_o = cur_w.data;

  // Ack goes back to the granted tile only
  always_comb begin
    flit_ack_o          = '0;
    flit_ack_o[grant_q] = locked_q && out_ack_i;
  end

  // Next requester after the last grant
  always_comb begin
    int unsigned idx;
    pick_valid = 1'b0;
    pick       = '0;
    for (int unsigned k = 1; k <= NumTiles; k++) begin
      idx = (32'(last_q) + k) % NumTiles;
      if (!pick_valid && flit_req_i[idx]) begin
        pick_valid = 1'b1;
        pick       = IdxWidth'(idx);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Grant and packet tracking
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      locked_q   <= 1'b0;
      ack_seen_q <= 1'b0;
      hdr_next_q <= 1'b1;
      grant_q    <= '0;
      last_q     <= IdxWidth'(NumTiles - 1);
      rem_q      <= '0;
    end else if (!locked_q) begin
      if (pick_valid) begin
        locked_q   <= 1'b1;
        grant_q    <= pick;
        hdr_next_q <= 1'b1;
      end
    end else if (!ack_seen_q) begin
      if (out_req_o && out_ack_i) begin
        ack_seen_q <= 1'b1;
        if (hdr_next_q) begin
          hdr_next_q <= 1'b0;
          rem_q      <= cur_w.hdr.len;
        end else begin
          rem_q <= rem_q - 8'd1;
        end
      end
    end else if (!out_ack_i) begin
      ack_seen_q <= 1'b0;
      // Last flit of the packet fully handshaken
      if (rem_q == '0) begin
        locked_q <= 1'b0;
        last_q   <= grant_q;
      end
    end
  end

  a_ack_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(flit_ack_o));

endmodule

// File: logic/tg_cluster_top.sv
`timescale 1ns/1ps
// Traffic-generation cluster top level
// Programming dispatcher, generator tiles and flit collector
module tg_cluster_top #(
  parameter int unsigned NumTiles = 4
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            cfg_req_i,
  input  logic                            cfg_we_i,
  input  logic [tg_pkg::CfgAddrWidth-1:0] cfg_addr_i,
  input  logic [tg_pkg::FlitWidth-1:0]    cfg_wdata_i,
  output logic                            cfg_ack_o,
  output logic [tg_pkg::FlitWidth-1:0]    cfg_rdata_o,
  output logic                            out_req_o,
  output logic [tg_pkg::FlitWidth-1:0]    out_data_o,
  input  logic                            out_ack_i
);
  import tg_pkg::*;

  logic [NumTiles-1:0]                tile_req;
  logic [NumTiles-1:0]                tile_ack;
  logic                               tile_we;
  logic [RegIdxWidth-1:0]             tile_reg;
  logic [FlitWidth-1:0]               tile_wdata;
  logic [NumTiles-1:0][FlitWidth-1:0] tile_rdata;
  logic [NumTiles-1:0]                flit_req;
  logic [NumTiles-1:0]                flit_ack;
  logic [NumTiles-1:0][FlitWidth-1:0] flit_data;

  cfg_dispatch #(
    .NumTiles(NumTiles)
  ) i_dispatch (
    .clk_i,
    .reset_i,
    .cfg_req_i,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .cfg_ack_o,
    .cfg_rdata_o,
    .tile_req_o  (tile_req),
    .tile_we_o   (tile_we),
    .tile_reg_o  (tile_reg),
    .tile_wdata_o(tile_wdata),
    .tile_ack_i  (tile_ack),
    .tile_rdata_i(tile_rdata)
  );

  for (genvar t = 0; t < NumTiles; t++) begin : g_tile
    tg_tile #(
      .TileId(t)
    ) i_tile (
      .clk_i,
      .reset_i,
      .cfg_req_i  (tile_req[t]),
      .cfg_we_i   (tile_we),
      .cfg_reg_i  (tile_reg),
      .cfg_wdata_i(tile_wdata),
      .cfg_ack_o  (tile_ack[t]),
      .cfg_rdata_o(tile_rdata[t]),
      .flit_req_o (flit_req[t]),
      .flit_data_o(flit_data[t]),
      .flit_ack_i (flit_ack[t])
    );
  end

  flit_collector #(
    .NumTiles(NumTiles)
  ) i_collector (
    .clk_i,
    .reset_i,
    .flit_req_i (flit_req),
    .flit_data_i(flit_data),
    .flit_ack_o (flit_ack),
    .out_req_o,
    .out_data_o,
    .out_ack_i
  );

endmodule

// File: bench/tb_tasks.svh
// Bench tasks for the traffic-generator cluster
// Four-phase waits, programming accesses, flit intake and packet check
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [7:0] cfg_addr(input int tile, input logic [2:0] idx);
  return {5'(tile), idx};
endfunction

function automatic int pick_delay(input int max_delay);
  if (max_delay == 0) return 0;
  return int'($urandom_range(max_delay, 0));
endfunction

task automatic wait_cfg_ack(input logic level);
  int n;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
    if (n > TimeoutCycles) begin
      $display("Timed out waiting for cfg_ack_o to become %0d", level);
      report_failure();
    end
  end while (cfg_ack_o !== level);
endtask

task automatic wait_out_req(input logic level);
  int n;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
    if (n > TimeoutCycles) begin
      $display("Timed out waiting for out_req_o to become %0d", level);
      report_failure();
    end
  end while (out_req_o !== level);
endtask

task automatic cfg_write(input logic [7:0] addr, input logic [31:0] data);
  @(posedge clk_i);
  cfg_addr_i  <= addr;
  cfg_wdata_i <= data;
  cfg_we_i    <= 1'b1;
  cfg_req_i   <= 1'b1;
  wait_cfg_ack(1'b1);
  cfg_req_i <= 1'b0;
  wait_cfg_ack(1'b0);
endtask

task automatic cfg_read(input logic [7:0] addr, output logic [31:0] data);
  @(posedge clk_i);
  cfg_addr_i <= addr;
  cfg_we_i   <= 1'b0;
  cfg_req_i  <= 1'b1;
  wait_cfg_ack(1'b1);
  data = cfg_rdata_o;
  cfg_req_i <= 1'b0;
  wait_cfg_ack(1'b0);
endtask

task automatic check_tile_regs(input int t);
  logic [31:0] d;
  cfg_read(cfg_addr(t, REG_DST), d);
  check_value("REG_DST", d, exp_dst[t]);
  cfg_read(cfg_addr(t, REG_LEN), d);
  check_value("REG_LEN", d, exp_len[t]);
  cfg_read(cfg_addr(t, REG_SEED), d);
  check_value("REG_SEED", d, exp_seed[t]);
  cfg_read(cfg_addr(t, REG_COUNT), d);
  check_value("REG_COUNT", d, exp_count[t]);
endtask

// Data must hold while the ack is withheld
task automatic take_flit(input int delay, output logic [31:0] data);
  wait_out_req(1'b1);
  data = out_data_o;
  if (delay > 0) begin
    repeat (delay) @(posedge clk_i);
    check_value("out_req_o", 32'(out_req_o), 32'd1);
    check_value("out_data_o", out_data_o, data);
  end
  out_ack_i <= 1'b1;
  wait_out_req(1'b0);
  out_ack_i <= 1'b0;
endtask

task automatic expect_quiet(input int cycles);
  repeat (cycles) begin
    @(posedge clk_i);
    check_value("out_req_o", 32'(out_req_o), 32'd0);
  end
endtask

task automatic check_packet(input int max_delay);
  flit_word_u  w;
  logic [31:0] d;
  int          s;
  take_flit(pick_delay(max_delay), d);
  w.data = d;
  s      = int'(w.hdr.src);
  assert ((s < NumTiles) && run_mask[s] && (pkts_seen[s] < exp_count[s])) else begin
    $display("Header names source %0d, which has no packet due", s);
    report_failure();
  end
  check_value("out_data_o.hdr.dst", 32'(w.hdr.dst), exp_dst[s]);
  check_value("out_data_o.hdr.seq", 32'(w.hdr.seq), next_seq[s] & 32'hff);
  check_value("out_data_o.hdr.len", 32'(w.hdr.len), exp_len[s]);
  for (int i = 0; i < int'(exp_len[s]); i++) begin
    model_lfsr[s] = lfsr_model(model_lfsr[s]);
    take_flit(pick_delay(max_delay), d);
    check_value("out_data_o payload", d, model_lfsr[s]);
  end
  next_seq[s]  = next_seq[s] + 32'd1;
  pkts_seen[s] = pkts_seen[s] + 32'd1;
endtask

`endif

// File: bench/tb_tg_cluster.sv
// Testbench for the traffic-generator cluster
// Clock and reset, DUT instance, reference model and directed tests
`timescale 1ns/1ps
module tb_tg_cluster;
  import tg_pkg::*;

  localparam int          NumTiles      = 4;
  localparam int          TimeoutCycles = 2000;
  localparam logic [31:0] Seed          = 32'he40a_a61a;
  localparam logic [31:0] TapsModel     = 32'h8020_0003;

  logic        clk_i;
  logic        reset_i;
  logic        cfg_req_i;
  logic        cfg_we_i;
  logic [7:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic        cfg_ack_o;
  logic [31:0] cfg_rdata_o;
  logic        out_req_o;
  logic [31:0] out_data_o;
  logic        out_ack_i;

  // Reference model with one entry per source tile
  logic [31:0]         exp_dst    [NumTiles];
  logic [31:0]         exp_len    [NumTiles];
  logic [31:0]         exp_seed   [NumTiles];
  logic [31:0]         exp_count  [NumTiles];
  logic [31:0]         model_lfsr [NumTiles];
  logic [31:0]         next_seq   [NumTiles];
  logic [31:0]         pkts_seen  [NumTiles];
  logic [NumTiles-1:0] run_mask;

  tg_cluster_top #(
    .NumTiles(NumTiles)
  ) uut (
    .clk_i,
    .reset_i,
    .cfg_req_i,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .cfg_ack_o,
    .cfg_rdata_o,
    .out_req_o,
    .out_data_o,
    .out_ack_i
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_failure();
    $display("Something failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
      report_failure();
    end
  endtask

  // Galois step shifts right and folds the taps in when a one drops out
  function automatic logic [31:0] lfsr_model(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    return state[0] ? (shifted ^ TapsModel) : shifted;
  endfunction

  `include "tb_tasks.svh"

  task automatic program_tile(input int t, input logic [31:0] dst, input logic [31:0] len,
                              input logic [31:0] seed, input logic [31:0] count);
    exp_dst[t]   = dst;
    exp_len[t]   = len;
    exp_seed[t]  = seed;
    exp_count[t] = count;
    cfg_write(cfg_addr(t, REG_DST), dst);
    cfg_write(cfg_addr(t, REG_LEN), len);
    cfg_write(cfg_addr(t, REG_SEED), seed);
    cfg_write(cfg_addr(t, REG_COUNT), count);
  endtask

  task automatic start_run(input logic [NumTiles-1:0] mask);
    run_mask = mask;
    for (int t = 0; t < NumTiles; t++) begin
      if (mask[t]) begin
        model_lfsr[t] = exp_seed[t];
        next_seq[t]   = '0;
        pkts_seen[t]  = '0;
        cfg_write(cfg_addr(t, REG_CTRL), 32'd1);
      end
    end
  endtask

  task automatic run_and_check(input logic [NumTiles-1:0] mask, input int max_delay);
    logic [31:0] d;
    int          total;
    total = 0;
    for (int t = 0; t < NumTiles; t++) begin
      if (mask[t]) total += int'(exp_count[t]);
    end
    repeat (total) check_packet(max_delay);
    for (int t = 0; t < NumTiles; t++) begin
      if (mask[t]) begin
        cfg_read(cfg_addr(t, REG_SENT), d);
        check_value("REG_SENT", d, exp_count[t]);
        cfg_read(cfg_addr(t, REG_CTRL), d);
        check_value("REG_CTRL busy", d, 32'd0);
      end
    end
    expect_quiet(20);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_register_access();
    logic [31:0] d;
    int          tile;
    logic [2:0]  idx;
    for (int t = 0; t < NumTiles; t++) begin
      for (int r = 0; r < 6; r++) begin
        cfg_read(cfg_addr(t, 3'(r)), d);
        check_value("cfg_rdata_o after reset", d, 32'd0);
      end
    end
    for (int t = 0; t < NumTiles; t++) begin
      program_tile(t, $urandom & 32'hff, $urandom_range(255, 1), $urandom | 32'd1, $urandom);
      check_tile_regs(t);
    end
    // Tile field past the last tile
    for (int k = 0; k < 8; k++) begin
      tile = int'($urandom_range(31, NumTiles));
      idx  = 3'($urandom_range(5, 0));
      cfg_write(cfg_addr(tile, idx), $urandom);
      cfg_read(cfg_addr(tile, idx), d);
      check_value("cfg_rdata_o out of range", d, 32'd0);
    end
    for (int t = 0; t < NumTiles; t++) begin
      check_tile_regs(t);
      cfg_read(cfg_addr(t, REG_CTRL), d);
      check_value("REG_CTRL busy", d, 32'd0);
    end
  endtask

  task automatic test_single_tile();
    program_tile(2, $urandom & 32'hff, $urandom_range(8, 1), $urandom | 32'd1,
                 $urandom_range(4, 2));
    start_run(4'b0100);
    run_and_check(4'b0100, 0);
  endtask

  task automatic test_concurrent();
    for (int t = 0; t < NumTiles; t++) begin
      program_tile(t, $urandom & 32'hff, $urandom_range(8, 1), $urandom | 32'd1,
                   $urandom_range(4, 1));
    end
    start_run('1);
    run_and_check('1, 0);
    // Same streams again behind a slow consumer
    start_run('1);
    run_and_check('1, 15);
  endtask

  task automatic test_busy_writes();
    logic [31:0] d;
    program_tile(1, $urandom & 32'hff, $urandom_range(8, 1), $urandom | 32'd1, 32'd3);
    start_run(4'b0010);
    cfg_read(cfg_addr(1, REG_CTRL), d);
    check_value("REG_CTRL busy", d, 32'd1);
    // Values that differ from the running ones
    cfg_write(cfg_addr(1, REG_LEN), exp_len[1] + 32'd1);
    cfg_write(cfg_addr(1, REG_SEED), exp_seed[1] ^ 32'h0000_0100);
    check_tile_regs(1);
    run_and_check(4'b0010, 3);
    // Empty run
    cfg_write(cfg_addr(1, REG_COUNT), 32'd0);
    exp_count[1] = '0;
    start_run(4'b0010);
    run_and_check(4'b0010, 0);
  endtask

  initial begin
    void'($urandom(Seed));
    reset_i     = 1'b1;
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    out_ack_i   = 1'b0;
    run_mask    = '0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    test_register_access();
    test_single_tile();
    test_concurrent();
    test_busy_writes();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: build.f
+incdir+bench
logic/tg_pkg.sv
logic/cfg_dispatch.sv
logic/tg_tile.sv
logic/flit_collector.sv
logic/tg_cluster_top.sv
bench/tb_tg_cluster.sv

// File: Makefile
# Verilator build and run for the traffic-generator cluster

TOP = tb_tg_cluster

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
